//--- filelist.f
src/dcache_pkg.sv
src/sram_1rw.sv
src/way_tracker.sv
src/line_merge.sv
src/cache_ctrl.sv
src/dcache_top.sv
verification/mem_model.sv
verification/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_dcache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verification/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    import dcache_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int RAND_REQS    = 200;
    // ten directed requests before the random mix
    localparam int NUM_REQS     = 10 + RAND_REQS;

    localparam logic [ADDR_W-1:0] ADDR_A = 32'h0000_1048;
    localparam logic [ADDR_W-1:0] ADDR_B = 32'h0003_0064;
    // three tags in set 0x20
    localparam logic [ADDR_W-1:0] ADDR_X = 32'h0010_0408;
    localparam logic [ADDR_W-1:0] ADDR_Y = 32'h0020_0414;
    localparam logic [ADDR_W-1:0] ADDR_Z = 32'h0030_0400;

    typedef struct packed {
        logic              is_wr;
        logic [ADDR_W-1:0] addr;
        line_t             line;
    } mem_evt_t;

    logic     clk;
    logic     rst;
    logic     cpu_valid;
    cpu_req_t cpu_req;
    logic     cpu_ready;
    logic     cpu_done;
    word_t    cpu_rdata;
    mem_rd_t  mem_rd;
    logic     mem_rvalid;
    line_t    mem_rdata;
    mem_wr_t  mem_wr;
    logic     mem_bvalid;

    integer   seed = 32'he781;
    int       errors;
    int       accepts;
    int       dones;
    int       last_wait;
    word_t    last_rdata;
    // reference memory with one entry per word-aligned address
    word_t    ref_mem [logic [ADDR_W-1:0]];
    mem_evt_t mem_log [$];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    dcache_top dcache_top_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_valid_i  (cpu_valid),
        .cpu_req_i    (cpu_req),
        .cpu_ready_o  (cpu_ready),
        .cpu_done_o   (cpu_done),
        .cpu_rdata_o  (cpu_rdata),
        .mem_rd_o     (mem_rd),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata),
        .mem_wr_o     (mem_wr),
        .mem_bvalid_i (mem_bvalid)
    );

    mem_model mem_model_i (
        .clk          (clk),
        .rst          (rst),
        .mem_rd_i     (mem_rd),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata),
        .mem_wr_i     (mem_wr),
        .mem_bvalid_o (mem_bvalid)
    );

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    //////////////////////////////////////////////////
    // monitors and protocol assertions
    //////////////////////////////////////////////////

    // handshakes sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (cpu_valid && cpu_ready) accepts++;
            if (cpu_done) dones++;
            if (mem_rd.ren && mem_rvalid) mem_log.push_back({1'b0, mem_rd.addr, mem_rdata});
            if (mem_wr.wen && mem_bvalid) mem_log.push_back({1'b1, mem_wr.addr, mem_wr.line});
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(mem_rd.ren && mem_wr.wen))
        else note_failure("memory read and write requested together");
    assert property (@(posedge clk) disable iff (rst)
        (mem_rd.ren && !mem_rvalid) |=> (mem_rd.ren && $stable(mem_rd.addr)))
        else note_failure("memory read request not held until rvalid");
    assert property (@(posedge clk) disable iff (rst)
        (mem_wr.wen && !mem_bvalid) |=> (mem_wr.wen && $stable(mem_wr.addr)
                                         && $stable(mem_wr.line)))
        else note_failure("memory write request not held until bvalid");
    assert property (@(posedge clk) disable iff (rst) mem_rvalid |=> !mem_rd.ren)
        else note_failure("ren still high after rvalid");
    assert property (@(posedge clk) disable iff (rst) mem_bvalid |=> !mem_wr.wen)
        else note_failure("wen still high after bvalid");
    assert property (@(posedge clk) disable iff (rst) cpu_done |-> !cpu_ready)
        else note_failure("cache ready while signalling done");

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////

    function automatic word_t fill_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    function automatic word_t model_word(input logic [ADDR_W-1:0] addr);
        if (ref_mem.exists({addr[ADDR_W-1:2], 2'b00})) begin
            return ref_mem[{addr[ADDR_W-1:2], 2'b00}];
        end
        return fill_word({addr[ADDR_W-1:2], 2'b00});
    endfunction

    // byte n taken from wdata when wsel bit n is set
    task automatic apply_write(input logic [ADDR_W-1:0] addr, input wsel_t wsel,
                               input word_t wdata);
        word_t w;
        w = model_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (wsel[b]) w[b*8 +: 8] = wdata[b*8 +: 8];
        end
        ref_mem[{addr[ADDR_W-1:2], 2'b00}] = w;
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
            else note_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else note_failure(what);
    endtask

    // starts and ends on a rising edge
    // last_wait counts cycles from accept to done
    task automatic cpu_access(input logic we, input wsel_t wsel,
                              input logic [ADDR_W-1:0] addr, input word_t wdata);
        cpu_valid <= 1'b1;
        cpu_req   <= '{we: we, wsel: wsel, addr: addr, wdata: wdata};
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        cpu_valid <= 1'b0;
        last_wait = 1;
        @(negedge clk);
        while (!cpu_done) begin
            @(negedge clk);
            last_wait++;
        end
        last_rdata = cpu_rdata;
        @(posedge clk);
    endtask

    task automatic read_and_compare(input logic [ADDR_W-1:0] addr);
        cpu_access(1'b0, 4'h0, addr, '0);
        expect_value("cpu_rdata_o", last_rdata, model_word(addr));
    endtask

    task automatic write_and_track(input logic [ADDR_W-1:0] addr, input wsel_t wsel,
                                   input word_t wdata);
        cpu_access(1'b1, wsel, addr, wdata);
        apply_write(addr, wsel, wdata);
    endtask

    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        int                log_start;

        rst       = 1'b1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        errors    = 0;
        accepts   = 0;
        dones     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        require(cpu_ready && !cpu_done, "cpu handshake wrong after reset");
        require(!mem_rd.ren && !mem_wr.wen, "memory request active after reset");
        @(posedge clk);

        // read miss and then a hit in the same line
        log_start = mem_log.size();
        read_and_compare(ADDR_A);
        require(mem_log.size() == log_start + 1, "read miss did not give exactly one memory read");
        if (mem_log.size() > log_start) begin
            require(!mem_log[log_start].is_wr, "read miss issued a memory write");
            expect_value("mem_rd_o.addr", mem_log[log_start].addr, line_base(ADDR_A));
        end
        log_start = mem_log.size();
        read_and_compare(ADDR_A + 32'd4);
        expect_value("cpu_done_o delay", last_wait, 1);
        require(mem_log.size() == log_start, "read hit issued a memory request");

        // byte-selected writes on a hit and on a miss
        write_and_track(ADDR_A + 32'd12, 4'b0101, 32'hdead_beef);
        read_and_compare(ADDR_A + 32'd12);
        write_and_track(ADDR_B, 4'b1010, 32'h1234_5678);
        read_and_compare(ADDR_B);

        // two dirty lines in one set and a third that evicts the older
        write_and_track(ADDR_X, 4'hf, 32'hcafe_f00d);
        write_and_track(ADDR_Y, 4'b0011, 32'h0000_a5a5);
        log_start = mem_log.size();
        read_and_compare(ADDR_Z);
        require(mem_log.size() == log_start + 2, "eviction did not give one write and one read");
        if (mem_log.size() == log_start + 2) begin
            require(mem_log[log_start].is_wr, "victim write-back did not come first");
            expect_value("mem_wr_o.addr", mem_log[log_start].addr, line_base(ADDR_X));
            expect_value("mem_wr_o.line[2]", mem_log[log_start].line[2], model_word(ADDR_X));
            require(!mem_log[log_start + 1].is_wr, "refill read missing after write-back");
            expect_value("mem_rd_o.addr", mem_log[log_start + 1].addr, line_base(ADDR_Z));
        end
        read_and_compare(ADDR_X);

        // random mix over sets 0x40 to 0x43 with eight tags
        for (int i = 0; i < RAND_REQS; i++) begin
            r    = $random(seed);
            addr = {20'h00a00 + {17'b0, r[2:0]}, 7'h40 + {5'b0, r[4:3]}, r[7:5], 2'b00};
            if (r[8]) begin
                wdata = $random(seed);
                write_and_track(addr, r[12:9], wdata);
            end else begin
                read_and_compare(addr);
            end
        end

        repeat (2) @(posedge clk);
        require(dones == accepts, "done pulses do not match accepted requests");
        $display("errors %0d, requests %0d, done pulses %0d", errors, accepts, dones);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // worst miss is well under 40 cycles
    initial begin
        repeat (RESET_CYCLES + NUM_REQS * 40) @(posedge clk);
        $display("watchdog expired after %0d of %0d requests", dones, NUM_REQS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire dcache_pkg::mem_rd_t mem_rd_i,
    output logic                     mem_rvalid_o,
    output dcache_pkg::line_t        mem_rdata_o,
    input  wire dcache_pkg::mem_wr_t mem_wr_i,
    output logic                     mem_bvalid_o
);

    import dcache_pkg::*;

    // lines written back so far, by line address
    line_t  lines [logic [ADDR_W-1:0]];
    integer seed = 32'he781;
    int     rd_wait;
    int     wr_wait;
    logic   rd_busy;
    logic   wr_busy;

    // power-up content of one word, from its byte address
    function automatic word_t fill_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic line_t read_line(input logic [ADDR_W-1:0] addr);
        line_t l;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = fill_word(addr + 32'(w * 4));
        end
        return l;
    endfunction

    // one answer per request, 0 to 5 cycles late
    always @(posedge clk) begin
        if (rst) begin
            rd_busy      <= 1'b0;
            rd_wait      <= 0;
            mem_rvalid_o <= 1'b0;
            mem_rdata_o  <= '0;
            wr_busy      <= 1'b0;
            wr_wait      <= 0;
            mem_bvalid_o <= 1'b0;
        end else begin
            // ren is still high on the edge after rvalid
            if (mem_rvalid_o) begin
                mem_rvalid_o <= 1'b0;
                rd_busy      <= 1'b0;
            end else if (!rd_busy) begin
                if (mem_rd_i.ren) begin
                    rd_busy <= 1'b1;
                    rd_wait <= {$random(seed)} % 6;
                end
            end else if (rd_wait == 0) begin
                mem_rvalid_o <= 1'b1;
                mem_rdata_o  <= read_line(mem_rd_i.addr);
            end else begin
                rd_wait <= rd_wait - 1;
            end

            if (mem_bvalid_o) begin
                mem_bvalid_o <= 1'b0;
                wr_busy      <= 1'b0;
            end else if (!wr_busy) begin
                if (mem_wr_i.wen) begin
                    wr_busy <= 1'b1;
                    wr_wait <= {$random(seed)} % 6;
                end
            end else if (wr_wait == 0) begin
                lines[mem_wr_i.addr] = mem_wr_i.line;
                mem_bvalid_o <= 1'b1;
            end else begin
                wr_wait <= wr_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cpu_valid_i,
    input  wire dcache_pkg::cpu_req_t cpu_req_i,
    output logic                      cpu_ready_o,
    output logic                      cpu_done_o,
    output dcache_pkg::word_t         cpu_rdata_o,
    output dcache_pkg::mem_rd_t       mem_rd_o,
    input  wire logic                 mem_rvalid_i,
    input  wire dcache_pkg::line_t    mem_rdata_i,
    output dcache_pkg::mem_wr_t       mem_wr_o,
    input  wire logic                 mem_bvalid_i
);

    import dcache_pkg::*;

    cpu_req_t           req;
    logic [INDEX_W-1:0] ram_index;
    logic [1:0]         tag_we;
    logic [1:0]         data_we;
    line_t              ram_wline;
    line_t              merge_base;
    line_t              merged_line;
    logic               tracker_update;
    logic               fill;
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_dirty;
    tag_t               victim_tag;
    tag_t               tag_rdata [2];
    line_t              line_rdata [2];

    cache_ctrl ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .cpu_valid_i      (cpu_valid_i),
        .cpu_req_i        (cpu_req_i),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .victim_line_i    (line_rdata[victim_way]),
        .merged_line_i    (merged_line),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_bvalid_i     (mem_bvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .cpu_ready_o      (cpu_ready_o),
        .cpu_done_o       (cpu_done_o),
        .req_o            (req),
        .ram_index_o      (ram_index),
        .tag_we_o         (tag_we),
        .data_we_o        (data_we),
        .ram_wline_o      (ram_wline),
        .merge_base_o     (merge_base),
        .tracker_update_o (tracker_update),
        .fill_o           (fill),
        .mem_rd_o         (mem_rd_o),
        .mem_wr_o         (mem_wr_o)
    );

    way_tracker #(
        .SETS (NUM_SETS)
    ) tracker_i (
        .clk            (clk),
        .rst            (rst),
        .tag0_i         (tag_rdata[0]),
        .tag1_i         (tag_rdata[1]),
        .req_addr_i     (req.addr),
        .update_i       (tracker_update),
        .fill_i         (fill),
        .write_i        (req.we),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // shared by the hit and refill paths
    line_merge merge_i (
        .base_i     (merge_base),
        .word_sel_i (addr_word(req.addr)),
        .wsel_i     (req.wsel),
        .wdata_i    (req.wdata),
        .we_i       (req.we),
        .line_o     (merged_line),
        .word_o     (cpu_rdata_o)
    );

    // tag and data ram per way
    for (genvar w = 0; w < 2; w++) begin : g_way
        sram_1rw #(
            .payload_t (tag_t),
            .DEPTH     (NUM_SETS)
        ) tag_ram_i (
            .clk     (clk),
            .addr_i  (ram_index),
            .we_i    (tag_we[w]),
            .wdata_i (addr_tag(req.addr)),
            .rdata_o (tag_rdata[w])
        );

        sram_1rw #(
            .payload_t (line_t),
            .DEPTH     (NUM_SETS)
        ) data_ram_i (
            .clk     (clk),
            .addr_i  (ram_index),
            .we_i    (data_we[w]),
            .wdata_i (ram_wline),
            .rdata_o (line_rdata[w])
        );
    end

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           cpu_valid_i,
    input  wire dcache_pkg::cpu_req_t           cpu_req_i,
    input  wire logic                           hit_i,
    input  wire logic                           hit_way_i,
    input  wire logic                           victim_way_i,
    input  wire logic                           victim_dirty_i,
    input  wire dcache_pkg::tag_t               victim_tag_i,
    input  wire dcache_pkg::line_t              victim_line_i,
    input  wire dcache_pkg::line_t              merged_line_i,
    input  wire logic                           mem_rvalid_i,
    input  wire logic                           mem_bvalid_i,
    input  wire dcache_pkg::line_t              mem_rdata_i,
    output logic                                cpu_ready_o,
    output logic                                cpu_done_o,
    output dcache_pkg::cpu_req_t                req_o,
    output logic [dcache_pkg::INDEX_W-1:0]      ram_index_o,
    output logic [1:0]                          tag_we_o,
    output logic [1:0]                          data_we_o,
    output dcache_pkg::line_t                   ram_wline_o,
    output dcache_pkg::line_t                   merge_base_o,
    output logic                                tracker_update_o,
    output logic                                fill_o,
    output dcache_pkg::mem_rd_t                 mem_rd_o,
    output dcache_pkg::mem_wr_t                 mem_wr_o
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        REFILL
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   accept;
    logic   hit_done;
    logic   fill_done;

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    assign cpu_ready_o = (state_q == IDLE);
    assign accept      = cpu_valid_i && cpu_ready_o;
    assign hit_done    = (state_q == COMPARE) && hit_i;
    assign fill_done   = (state_q == REFILL) && mem_rvalid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (hit_i) begin
                    state_d = IDLE;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            // victim goes out before the refill read
            WRITEBACK: begin
                if (mem_bvalid_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_rvalid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request held for the whole miss
    always_ff @(posedge clk) begin
        if (accept) begin
            req_o <= cpu_req_i;
        end
    end

    //////////////////////////////////////////////////
    // ram and tracker control
    //////////////////////////////////////////////////

    // lookup starts on the accept edge
    assign ram_index_o = (state_q == IDLE) ? addr_index(cpu_req_i.addr)
                                           : addr_index(req_o.addr);

    assign merge_base_o = (state_q == REFILL) ? mem_rdata_i : victim_line_i;
    assign ram_wline_o  = merged_line_i;

    assign tag_we_o  = fill_done ? (2'b01 << victim_way_i) : 2'b00;
    assign data_we_o = (hit_done && req_o.we) ? (2'b01 << hit_way_i) : tag_we_o;

    assign tracker_update_o = hit_done || fill_done;
    assign fill_o           = fill_done;

    //////////////////////////////////////////////////
    // memory handshakes
    //////////////////////////////////////////////////

    assign mem_rd_o.ren  = (state_q == REFILL);
    assign mem_rd_o.addr = line_addr(addr_tag(req_o.addr), addr_index(req_o.addr));

    // victim tag and line stay on the ram outputs until the fill
    assign mem_wr_o.wen  = (state_q == WRITEBACK);
    assign mem_wr_o.addr = line_addr(victim_tag_i, addr_index(req_o.addr));
    assign mem_wr_o.line = victim_line_i;

    // one done per accepted request
    assign cpu_done_o = hit_done || fill_done;

endmodule

`default_nettype wire

//--- src/line_merge.sv
`timescale 1ns/1ns
`default_nettype none

module line_merge (
    input  wire dcache_pkg::line_t                 base_i,
    input  wire logic [dcache_pkg::WORD_SEL_W-1:0] word_sel_i,
    input  wire dcache_pkg::wsel_t                 wsel_i,
    input  wire dcache_pkg::word_t                 wdata_i,
    input  wire logic                              we_i,
    output dcache_pkg::line_t                      line_o,
    output dcache_pkg::word_t                      word_o
);

    import dcache_pkg::*;

    word_t base_word;
    word_t new_word;

    assign base_word = base_i[word_sel_i];

    // byte lanes picked by wsel
    always_comb begin
        new_word = base_word;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (wsel_i[b]) begin
                new_word[b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

    // only the addressed word changes
    always_comb begin
        line_o = base_i;
        if (we_i) begin
            line_o[word_sel_i] = new_word;
        end
    end

    // read data comes from the result line
    assign word_o = line_o[word_sel_i];

endmodule

`default_nettype wire

//--- src/way_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module way_tracker #(
    parameter int SETS = 128
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire dcache_pkg::tag_t              tag0_i,
    input  wire dcache_pkg::tag_t              tag1_i,
    input  wire logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  wire logic                          update_i,
    input  wire logic                          fill_i,
    input  wire logic                          write_i,
    output logic                               hit_o,
    output logic                               hit_way_o,
    output logic                               victim_way_o,
    output logic                               victim_dirty_o,
    output dcache_pkg::tag_t                   victim_tag_o
);

    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    // per set state, bit n for way n
    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0][1:0] dirty_q;
    // lru points at the way to replace next
    logic [SETS-1:0]      lru_q;

    logic [IDX_W-1:0] set_idx;
    tag_t             req_tag;
    logic [1:0]       way_hit;
    logic             upd_way;

    //////////////////////////////////////////////////
    // tag compare
    //////////////////////////////////////////////////

    assign set_idx = req_addr_i[OFFSET_W +: IDX_W];
    assign req_tag = addr_tag(req_addr_i);

    assign way_hit[0] = valid_q[set_idx][0] && (tag0_i == req_tag);
    assign way_hit[1] = valid_q[set_idx][1] && (tag1_i == req_tag);

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // a hit selects the hit way so the line port carries the hit line
    assign victim_way_o   = hit_o ? hit_way_o : lru_q[set_idx];
    assign victim_dirty_o = valid_q[set_idx][victim_way_o] && dirty_q[set_idx][victim_way_o];
    assign victim_tag_o   = victim_way_o ? tag1_i : tag0_i;

    //////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////

    assign upd_way = fill_i ? victim_way_o : hit_way_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (update_i) begin
            lru_q[set_idx] <= ~upd_way;
            if (fill_i) begin
                // fresh line is dirty only for a write miss
                valid_q[set_idx][upd_way] <= 1'b1;
                dirty_q[set_idx][upd_way] <= write_i;
            end else if (write_i) begin
                dirty_q[set_idx][upd_way] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sram_1rw.sv
`timescale 1ns/1ns
`default_nettype none

module sram_1rw #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 128
) (
    input  wire logic                     clk,
    input  wire logic [$clog2(DEPTH)-1:0] addr_i,
    input  wire logic                     we_i,
    input  wire payload_t                 wdata_i,
    output payload_t                      rdata_o
);

    localparam int AW = $clog2(DEPTH);

    payload_t mem [DEPTH];
    logic [AW-1:0] rd_addr;

    assign rd_addr = addr_i;

    // whole-entry write, old data on the read port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;
    localparam int WORD_SEL_W     = 3;
    localparam int INDEX_W        = 7;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [WORD_W-1:0] word_t;
    // word 0 in the low bits
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WORD_W/8-1:0] wsel_t;

    typedef struct packed {
        logic              we;
        wsel_t             wsel;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              ren;
        logic [ADDR_W-1:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic              wen;
        logic [ADDR_W-1:0] addr;
        line_t             line;
    } mem_wr_t;

    //////////////////////////////////////////////////
    // address fields
    //////////////////////////////////////////////////

    function automatic tag_t addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    // bits 4 to 2
    function automatic logic [WORD_SEL_W-1:0] addr_word(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1 -: WORD_SEL_W];
    endfunction

    // line-aligned address from tag and set
    function automatic logic [ADDR_W-1:0] line_addr(
        input tag_t               tag,
        input logic [INDEX_W-1:0] index
    );
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire
